//--- Makefile
# Verilator build and run of the LSU testbench
SIM := obj_dir/lsuTbSim

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): all.f verilog/*.sv verif/lsuTb.sv verif/lsuCheck.svh
	verilator --binary --timing --timescale 1ns/1ps -f all.f \
	  --top-module lsuTb -Mdir obj_dir -o lsuTbSim

# Pass only when the simulation prints the pass message
run: compile
	@out=$$(./$(SIM) 2>&1); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+verif
verilog/lsuPkg.sv
verilog/lrscReservation.sv
verilog/storeDataPath.sv
verilog/loadDataPath.sv
verilog/apbRequester.sv
verilog/lsuCtrl.sv
verilog/lsuTop.sv
verif/lsuTb.sv

//--- verif/lsuStimulus.txt
# rw funct3 lrsc bigEndian adr writeData expReadData expFlags, all hex, rw 1 store 2 load
# funct3 0 b 1 h 2 w 4 bu 5 hu, flags bits squashSc loadMisal storeMisal accessFault
1 2 0 0 00000100 12345678 00000000 0
2 2 0 0 00000100 00000000 12345678 0
1 0 0 0 00000101 deadbeab 00000000 0
2 0 0 0 00000101 00000000 ffffffab 0
2 4 0 0 00000101 00000000 000000ab 0
1 1 0 0 00000102 11228765 00000000 0
2 1 0 0 00000102 00000000 ffff8765 0
2 5 0 0 00000102 00000000 00008765 0
2 1 0 0 00000100 00000000 ffffab78 0
1 2 0 1 00000104 a1b2c3d4 00000000 0
2 2 0 1 00000104 00000000 a1b2c3d4 0
1 0 0 1 00000104 0000005f 00000000 0
2 4 0 1 00000104 00000000 0000005f 0
2 0 0 1 00000107 00000000 ffffffa1 0
1 1 0 1 00000106 0000beef 00000000 0
2 1 0 1 00000106 00000000 ffffbeef 0
2 5 0 1 00000104 00000000 0000c35f 0
2 1 0 0 00000101 00000000 00000000 4
2 2 0 0 00000102 00000000 00000000 4
1 1 0 0 00000103 00005555 00000000 2
1 2 0 0 00000101 66666666 00000000 2
2 2 1 0 00000108 00000000 00000000 0
1 2 1 0 0000010c cafef00d 00000000 0
1 2 1 0 0000010c 11111111 00000000 8
2 2 0 0 0000010c 00000000 cafef00d 0
2 2 1 0 00000108 00000000 00000000 0
1 2 1 0 00000110 22222222 00000000 8
2 2 0 0 00000110 00000000 00000000 0
1 2 0 0 00000400 33333333 00000000 1
2 2 0 0 00000404 00000000 00000000 1

//--- verif/lsuCheck.svh
`ifndef LSU_CHECK_SVH
`define LSU_CHECK_SVH

  // Response against the expected columns of the stimulus file
  task automatic checkRsp(input lsuPkg::lsuRspT got, input lsuPkg::lsuRspT want);
    logic bad;
    bad = 1'b0;
    if (got.readData !== want.readData) begin
      $display("ERR lsuRsp.readData got %h expected %h", got.readData, want.readData);
      bad = 1'b1;
    end
    if (got.squashSc !== want.squashSc) begin
      $display("ERR lsuRsp.squashSc got %h expected %h", got.squashSc, want.squashSc);
      bad = 1'b1;
    end
    if (got.loadMisaligned !== want.loadMisaligned) begin
      $display("ERR lsuRsp.loadMisaligned got %h expected %h", got.loadMisaligned,
               want.loadMisaligned);
      bad = 1'b1;
    end
    if (got.storeMisaligned !== want.storeMisaligned) begin
      $display("ERR lsuRsp.storeMisaligned got %h expected %h", got.storeMisaligned,
               want.storeMisaligned);
      bad = 1'b1;
    end
    if (got.accessFault !== want.accessFault) begin
      $display("ERR lsuRsp.accessFault got %h expected %h", got.accessFault,
               want.accessFault);
      bad = 1'b1;
    end
    if (bad) failRun("response differs from the stimulus file");
  endtask

  // Write transfer in its completing access cycle
  task automatic checkApbWrite(input lsuPkg::apbReqT got, input lsuPkg::apbReqT want);
    if (got !== want) begin
      $display("ERR apbReq.paddr got %h expected %h", got.paddr, want.paddr);
      $display("ERR apbReq.pwdata got %h expected %h", got.pwdata, want.pwdata);
      $display("ERR apbReq.pstrb got %h expected %h", got.pstrb, want.pstrb);
      $display("ERR apbReq.psel/penable/pwrite got %h%h%h expected %h%h%h", got.psel,
               got.penable, got.pwrite, want.psel, want.penable, want.pwrite);
      failRun("APB write differs from the replication and swap rules");
    end
  endtask

`endif

//--- verif/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

  localparam int          timeoutCycles = 200;            // Limit for every wait loop
  localparam logic [31:0] errBase       = 32'h0000_0400;  // pslverr region starts here

  logic            clk;
  logic            arstN;
  logic            reqValid;
  lsuPkg::lsuReqT  lsuReq;
  logic            reqReady;
  logic            rspValid;
  lsuPkg::lsuRspT  lsuRsp;
  lsuPkg::apbReqT  apbReq;
  lsuPkg::apbRspT  apbRsp;

  logic [31:0]     mem [0:255];   // Word memory behind the APB slave
  int              setupCount;    // Setup phases seen on the bus
  int              doneCount;     // Completed transfers
  int              waitLeft;      // Wait states left in this transfer
  lsuPkg::apbReqT  expWrite;      // Write expected for the current request

  lsuTop #(.ReservationGranuleBits(3)) lsuTop_inst (
    .clk, .arstN, .reqValid, .lsuReq, .reqReady, .rspValid, .lsuRsp, .apbReq, .apbRsp
  );

  task automatic failRun(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  `include "lsuCheck.svh"

  // Lane placement from the replication and swap rules
  function automatic lsuPkg::apbReqT expectedWrite(input lsuPkg::lsuReqT req);
    lsuPkg::apbReqT w;
    int size;
    int first;
    int lane;
    w = '0;
    size = (req.funct3[1:0] == 2'b00) ? 1 : (req.funct3[1:0] == 2'b01) ? 2 : 4;
    first = int'(req.adr[1:0]);   // Aligned stores only reach the bus
    w.psel = 1'b1;
    w.penable = 1'b1;
    w.pwrite = 1'b1;
    w.paddr = {req.adr[31:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      lane = req.bigEndian ? 3 - i : i;   // Byte i of the little-endian view
      w.pwdata[8*lane +: 8] = req.writeData[8*(i % size) +: 8];
      w.pstrb[lane] = (i >= first) && (i < first + size);
    end
    return w;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////////////
  // APB slave with random wait states
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    int seedVal;
    seedVal = $urandom(32'hffc1);   // Fixes the wait-state stream
    apbRsp = '0;
    setupCount = 0;
    doneCount = 0;
    waitLeft = 0;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    forever begin
      @(negedge clk);
      if (apbReq.psel && !apbReq.penable) begin
        waitLeft = int'($urandom % 4);   // 0 to 3 wait states
        apbRsp.pready <= 1'b0;
        setupCount <= setupCount + 1;
      end else if (apbReq.psel && apbReq.penable) begin
        if (waitLeft > 0) begin
          waitLeft = waitLeft - 1;
        end else begin
          if (apbReq.pwrite) checkApbWrite(apbReq, expWrite);
          apbRsp.pready <= 1'b1;
          doneCount <= doneCount + 1;
          if (apbReq.paddr >= errBase) begin
            apbRsp.pslverr <= 1'b1;   // Error region leaves memory untouched
            apbRsp.prdata <= '0;
          end else begin
            apbRsp.pslverr <= 1'b0;
            apbRsp.prdata <= mem[apbReq.paddr[9:2]];
            for (int i = 0; i < 4; i++) begin
              if (apbReq.pwrite && apbReq.pstrb[i]) begin
                mem[apbReq.paddr[9:2]][8*i +: 8] = apbReq.pwdata[8*i +: 8];
              end
            end
          end
        end
      end else begin
        apbRsp.pready <= 1'b0;
        apbRsp.pslverr <= 1'b0;
        apbRsp.prdata <= $urandom;   // Junk outside completion
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Request driver
  //////////////////////////////////////////////////////////////////////////////

  initial begin
    int              fd;
    int              n;
    int              reqNum;
    int              cycles;
    int              setupBefore;
    int              doneBefore;
    string           line;
    logic [31:0]     rwIn;
    logic [31:0]     f3In;
    logic [31:0]     lrscIn;
    logic [31:0]     beIn;
    logic [31:0]     adrIn;
    logic [31:0]     wdIn;
    logic [31:0]     rdIn;
    logic [31:0]     flagsIn;
    logic            expectBus;
    lsuPkg::lsuReqT  req;
    lsuPkg::lsuRspT  expRsp;
    arstN = 1'b0;
    reqValid = 1'b0;
    lsuReq = '0;
    repeat (16) @(negedge clk);
    arstN = 1'b1;
    @(negedge clk);
    if (!reqReady || rspValid || apbReq.psel || apbReq.penable) begin
      failRun("outputs not idle after reset");
    end
    fd = $fopen("verif/lsuStimulus.txt", "r");
    if (fd == 0) failRun("cannot open verif/lsuStimulus.txt");
    reqNum = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") continue;   // Header or blank
      n = $sscanf(line, "%h %h %h %h %h %h %h %h", rwIn, f3In, lrscIn, beIn, adrIn, wdIn,
                  rdIn, flagsIn);
      if (n != 8) failRun($sformatf("bad stimulus line: %s", line));
      req.rw = lsuPkg::memRwT'(rwIn[1:0]);
      req.funct3 = f3In[2:0];
      req.lrsc = lrscIn[0];
      req.bigEndian = beIn[0];
      req.adr = adrIn;
      req.writeData = wdIn;
      expRsp.readData = rdIn;
      expRsp.squashSc = flagsIn[3];
      expRsp.loadMisaligned = flagsIn[2];
      expRsp.storeMisaligned = flagsIn[1];
      expRsp.accessFault = flagsIn[0];
      // Faults and failed SC never reach the bus
      expectBus = !(flagsIn[3] | flagsIn[2] | flagsIn[1]);
      expWrite = expectedWrite(req);
      reqNum = reqNum + 1;

      cycles = 0;
      while (!reqReady) begin
        @(negedge clk);
        cycles = cycles + 1;
        if (cycles > timeoutCycles) failRun("timeout waiting for reqReady");
      end
      lsuReq = req;
      reqValid = 1'b1;
      setupBefore = setupCount;
      doneBefore = doneCount;
      @(negedge clk);   // Taken at this rising edge
      reqValid = 1'b0;
      lsuReq = '0;      // DUT works from its registered copy
      if (expectBus) begin
        cycles = 0;
        while (doneCount == doneBefore) begin
          if (reqReady) failRun("reqReady high while a request is in flight");
          @(negedge clk);
          cycles = cycles + 1;
          if (cycles > timeoutCycles) failRun("timeout waiting for the APB transfer");
        end
      end
      cycles = 0;
      while (!rspValid) begin
        if (reqReady) failRun("reqReady high while a request is in flight");
        @(negedge clk);
        cycles = cycles + 1;
        if (cycles > timeoutCycles) failRun("timeout waiting for rspValid");
      end
      if (reqReady) failRun("reqReady high together with rspValid");
      checkRsp(lsuRsp, expRsp);
      if ((setupCount - setupBefore) != (expectBus ? 1 : 0)) begin
        failRun($sformatf("wrong number of APB transfers for request %0d", reqNum));
      end
      @(negedge clk);
      if (!reqReady || rspValid) failRun("reqReady not back one cycle after rspValid");
    end
    $fclose(fd);
    if (reqNum == 0) begin
      failRun("no requests found in the stimulus file");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

//--- verilog/apbRequester.sv
`timescale 1ns/1ps

module apbRequester (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       start,     // Setup phase this cycle
  input  lsuPkg::lsuReqT             curReq,
  input  logic [lsuPkg::xlen-1:0]    pwdata,
  input  logic [lsuPkg::strbW-1:0]   pstrb,
  output lsuPkg::apbReqT             apbReq,
  input  lsuPkg::apbRspT             apbRsp,
  output logic                       done,      // pready seen in access
  output logic                       busErr,
  output logic [lsuPkg::xlen-1:0]    prdata
);

  logic                     accessQ;   // Access phase active
  logic                     errQ;      // Captured pslverr
  logic [lsuPkg::xlen-1:0]  rdataQ;    // Captured read word

  assign done = accessQ & apbRsp.pready;

  ////////////////////////////////////////////////////////////////////////////
  // APB phases
  ////////////////////////////////////////////////////////////////////////////

  // Setup is the start cycle, access repeats until pready
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      accessQ <= 1'b0;
      errQ    <= 1'b0;
    end else begin
      if (start) accessQ <= 1'b1;
      else if (done) accessQ <= 1'b0;
      if (start) errQ <= 1'b0;
      else if (done) errQ <= apbRsp.pslverr;   // Sampled only on completion
    end
  end

  always_ff @(posedge clk) begin
    if (done) rdataQ <= apbRsp.prdata;
  end

  // Address and data come from the held request
  assign apbReq.psel    = start | accessQ;
  assign apbReq.penable = accessQ;
  assign apbReq.pwrite  = (curReq.rw == lsuPkg::rwWrite);
  assign apbReq.paddr   = {curReq.adr[lsuPkg::xlen-1:lsuPkg::offW], {lsuPkg::offW{1'b0}}};
  assign apbReq.pwdata  = pwdata;
  assign apbReq.pstrb   = pstrb;

  // Live bus values in the done cycle, held copy afterwards
  assign prdata = done ? apbRsp.prdata : rdataQ;
  assign busErr = done ? apbRsp.pslverr : errQ;

endmodule

//--- verilog/loadDataPath.sv
`timescale 1ns/1ps

module loadDataPath (
  input  lsuPkg::lsuReqT             curReq,
  input  logic [lsuPkg::xlen-1:0]    prdata,     // Raw word from the bus
  output logic [lsuPkg::xlen-1:0]    loadData    // Extended result for the core
);

  localparam int xlen = lsuPkg::xlen;

  logic [xlen-1:0]          swapped;   // Byte-reversed bus word
  logic [xlen-1:0]          word;      // Word in little-endian order
  logic [xlen-1:0]          shifted;   // Addressed subword moved to bit 0
  logic [lsuPkg::offW-1:0]  byteOff;
  logic                     signExt;   // funct3 bit 2 clear means signed

  ////////////////////////////////////////////////////////////////////////////
  // Endian swap
  ////////////////////////////////////////////////////////////////////////////

  assign swapped = {<<8{prdata}};
  assign word    = curReq.bigEndian ? swapped : prdata;

  ////////////////////////////////////////////////////////////////////////////
  // Subword select and extension
  ////////////////////////////////////////////////////////////////////////////

  assign byteOff = curReq.adr[lsuPkg::offW-1:0];
  assign shifted = word >> {byteOff, 3'b000};    // Byte offset to bit offset
  assign signExt = ~curReq.funct3[2];

  always_comb begin
    case ({1'b0, curReq.funct3[1:0]})
      lsuPkg::f3Byte: begin
        loadData = {{(xlen-8){signExt & shifted[7]}}, shifted[7:0]};
      end
      lsuPkg::f3Half: begin
        loadData = {{(xlen-16){signExt & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        loadData = word;   // Word loads need no shift
      end
    endcase
  end

endmodule

//--- verilog/lrscReservation.sv
`timescale 1ns/1ps

module lrscReservation #(
  parameter int ReservationGranuleBits = 3   // Granule of 2**n bytes
) (
  input  logic            clk,
  input  logic            arstN,
  input  lsuPkg::lsuReqT  curReq,
  input  logic            resolve,    // Request decided this cycle
  output logic            scFail
);

  localparam int tagW = lsuPkg::xlen - ReservationGranuleBits;

  logic             resValid;   // Reservation held
  logic [tagW-1:0]  resTag;     // Reserved granule address
  logic [tagW-1:0]  reqTag;     // Granule of the current request
  logic             isLr;
  logic             isSc;

  assign reqTag = curReq.adr[lsuPkg::xlen-1:ReservationGranuleBits];
  assign isLr   = curReq.lrsc & (curReq.rw == lsuPkg::rwRead);
  assign isSc   = curReq.lrsc & (curReq.rw == lsuPkg::rwWrite);

  // SC needs a live reservation on its own granule
  assign scFail = isSc & (~resValid | (resTag != reqTag));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid <= 1'b0;
    end else if (resolve) begin
      if (isLr) begin
        resValid <= 1'b1;
      end else if (isSc) begin
        resValid <= 1'b0;   // Any SC ends the reservation
      end
    end
  end

  // Granule address, meaningful only with resValid
  always_ff @(posedge clk) begin
    if (resolve && isLr) resTag <= reqTag;
  end

endmodule

//--- verilog/lsuCtrl.sv
`timescale 1ns/1ps

module lsuCtrl (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic                     reqValid,
  input  lsuPkg::lsuReqT           lsuReq,
  output logic                     reqReady,
  output lsuPkg::lsuReqT           curReq,     // Registered request
  output logic                     resolve,    // One pulse per request
  input  logic                     scFail,
  output logic                     start,
  input  logic                     done,
  input  logic                     busErr,
  input  logic [lsuPkg::xlen-1:0]  loadData,
  output logic                     rspValid,
  output lsuPkg::lsuRspT           lsuRsp
);

  typedef enum logic [1:0] {
    stIdle,      // Waiting for a request
    stIssue,     // Decide bus or skip, launch transfer
    stWait,      // APB transfer in flight
    stRespond    // Response pulse
  } stateT;

  stateT           state;
  stateT           stateNext;
  logic            accept;       // Request handshake
  logic            isRead;
  logic            isWrite;
  logic            misaligned;   // Address not aligned to the access size
  logic            skipBus;      // Answer without a transfer
  logic            rspLoad;
  lsuPkg::lsuRspT  rspNext;

  assign reqReady = (state == stIdle);   // One request in flight
  assign accept   = reqValid & reqReady;
  assign isRead   = (curReq.rw == lsuPkg::rwRead);
  assign isWrite  = (curReq.rw == lsuPkg::rwWrite);

  // Alignment against the access size
  always_comb begin
    case (curReq.funct3)
      lsuPkg::f3Half, lsuPkg::f3HalfU: misaligned = curReq.adr[0];
      lsuPkg::f3Word:                  misaligned = |curReq.adr[1:0];
      lsuPkg::f3Byte, lsuPkg::f3ByteU: misaligned = 1'b0;
      default:                         misaligned = 1'b0;   // Unused codes treated as bytes
    endcase
  end

  // Failed SC, fault or empty op never reaches the bus
  assign skipBus = misaligned | scFail | (curReq.rw == lsuPkg::rwNone);
  assign resolve = (state == stIssue);
  assign start   = (state == stIssue) & ~skipBus;
  assign rspLoad = ((state == stIssue) & skipBus) | ((state == stWait) & done);
  assign rspValid = (state == stRespond);

  ////////////////////////////////////////////////////////////////////////////
  // Next state and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      stIdle:    if (accept) stateNext = stIssue;
      stIssue:   stateNext = skipBus ? stRespond : stWait;
      stWait:    if (done) stateNext = stRespond;
      stRespond: stateNext = stIdle;
      default:   stateNext = stIdle;
    endcase
  end

  always_comb begin
    rspNext = '0;
    if (state == stIssue) begin
      // Skip path carries only the fault flags
      rspNext.loadMisaligned  = misaligned & isRead;
      rspNext.storeMisaligned = misaligned & isWrite;
      rspNext.squashSc        = scFail;
    end else begin
      rspNext.accessFault = busErr;
      rspNext.readData    = (isRead & ~busErr) ? loadData : '0;   // Zero for stores
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= stIdle;
    end else begin
      state <= stateNext;
    end
  end

  // Request and response payload
  always_ff @(posedge clk) begin
    if (accept) curReq <= lsuReq;
    if (rspLoad) lsuRsp <= rspNext;
  end

endmodule

//--- verilog/lsuPkg.sv
package lsuPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen  = 32;             // Data and address width
  localparam int strbW = xlen / 8;       // Byte lanes per word
  localparam int offW  = $clog2(strbW);  // Byte offset bits within a word

  ////////////////////////////////////////////////////////////////////////////
  // Access size, RISC-V funct3 encoding
  ////////////////////////////////////////////////////////////////////////////

  // Bit 2 selects zero extension on loads
  localparam logic [2:0] f3Byte  = 3'b000;
  localparam logic [2:0] f3Half  = 3'b001;
  localparam logic [2:0] f3Word  = 3'b010;
  localparam logic [2:0] f3ByteU = 3'b100;
  localparam logic [2:0] f3HalfU = 3'b101;

  // Read/write control, same coding as the core pipeline
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,
    rwRead  = 2'b10
  } memRwT;

  ////////////////////////////////////////////////////////////////////////////
  // Core side
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    memRwT             rw;          // Load, store or nothing
    logic [2:0]        funct3;      // Size and sign
    logic              lrsc;        // LR on a read, SC on a write
    logic              bigEndian;   // Memory seen big endian
    logic [xlen-1:0]   adr;         // Byte address
    logic [xlen-1:0]   writeData;   // Store data, low bits used for subwords
  } lsuReqT;

  typedef struct packed {
    logic [xlen-1:0]   readData;        // Extended load result
    logic              squashSc;        // SC failed, no write done
    logic              loadMisaligned;
    logic              storeMisaligned;
    logic              accessFault;     // Bus returned pslverr
  } lsuRspT;

  // APB requester outputs
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [xlen-1:0]   paddr;       // Always word aligned
    logic [xlen-1:0]   pwdata;
    logic [strbW-1:0]  pstrb;
  } apbReqT;

  // APB completion inputs
  typedef struct packed {
    logic              pready;
    logic [xlen-1:0]   prdata;
    logic              pslverr;     // Valid only with pready in access
  } apbRspT;

endpackage

//--- verilog/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
  parameter int ReservationGranuleBits = 3   // log2 of reservation granule in bytes
) (
  input  logic                clk,
  input  logic                arstN,
  // Core request, valid/ready
  input  logic                reqValid,
  input  lsuPkg::lsuReqT      lsuReq,
  output logic                reqReady,
  // Core response, one-cycle pulse
  output logic                rspValid,
  output lsuPkg::lsuRspT      lsuRsp,
  // APB requester port
  output lsuPkg::apbReqT      apbReq,
  input  lsuPkg::apbRspT      apbRsp
);

  lsuPkg::lsuReqT                 curReq;     // Request held for the whole transfer
  logic                           resolve;    // Reservation update strobe
  logic                           scFail;     // SC outside a valid reservation
  logic                           start;      // Launches the APB transfer
  logic                           done;       // APB transfer finished
  logic                           busErr;     // pslverr of the finished transfer
  logic [lsuPkg::xlen-1:0]        pwdata;     // Lane-placed store data
  logic [lsuPkg::strbW-1:0]       pstrb;      // Store byte strobes
  logic [lsuPkg::xlen-1:0]        prdata;     // Raw bus read word
  logic [lsuPkg::xlen-1:0]        loadData;   // Extended load result

  ////////////////////////////////////////////////////////////////////////////
  // Control and reservation
  ////////////////////////////////////////////////////////////////////////////

  lsuCtrl lsuCtrl_inst (
    .clk, .arstN, .reqValid, .lsuReq, .reqReady, .curReq, .resolve, .scFail,
    .start, .done, .busErr, .loadData, .rspValid, .lsuRsp
  );

  lrscReservation #(
    .ReservationGranuleBits(ReservationGranuleBits)
  ) lrscReservation_inst (
    .clk, .arstN, .curReq, .resolve, .scFail
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data paths and bus
  ////////////////////////////////////////////////////////////////////////////

  storeDataPath storeDataPath_inst (.curReq, .pwdata, .pstrb);

  loadDataPath loadDataPath_inst (.curReq, .prdata, .loadData);

  apbRequester apbRequester_inst (
    .clk, .arstN, .start, .curReq, .pwdata, .pstrb, .apbReq, .apbRsp,
    .done, .busErr, .prdata
  );

endmodule

//--- verilog/storeDataPath.sv
`timescale 1ns/1ps

module storeDataPath (
  input  lsuPkg::lsuReqT             curReq,
  output logic [lsuPkg::xlen-1:0]    pwdata,   // Store data placed on its lanes
  output logic [lsuPkg::strbW-1:0]   pstrb     // Byte write enables
);

  logic [lsuPkg::xlen-1:0]   repData;    // Subword replicated over the word
  logic [lsuPkg::xlen-1:0]   swapData;   // Byte-reversed copy
  logic [lsuPkg::strbW-1:0]  strb;       // Little-endian strobes
  logic [lsuPkg::strbW-1:0]  swapStrb;   // Lane-reversed strobes
  logic [lsuPkg::offW-1:0]   byteOff;

  assign byteOff = curReq.adr[lsuPkg::offW-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Replication and byte mask
  ////////////////////////////////////////////////////////////////////////////

  // Sign bit of funct3 ignored on stores
  always_comb begin
    case ({1'b0, curReq.funct3[1:0]})
      lsuPkg::f3Byte: begin
        repData = {lsuPkg::strbW{curReq.writeData[7:0]}};
        strb    = {{(lsuPkg::strbW-1){1'b0}}, 1'b1} << byteOff;
      end
      lsuPkg::f3Half: begin
        repData = {(lsuPkg::strbW/2){curReq.writeData[15:0]}};
        strb    = {{(lsuPkg::strbW-2){1'b0}}, 2'b11} << {byteOff[lsuPkg::offW-1:1], 1'b0};
      end
      default: begin
        repData = curReq.writeData;   // Full word
        strb    = '1;
      end
    endcase
  end

  // Big-endian memory sees bytes and lanes reversed
  assign swapData = {<<8{repData}};
  assign swapStrb = {<<{strb}};

  assign pwdata = curReq.bigEndian ? swapData : repData;
  assign pstrb  = curReq.bigEndian ? swapStrb : strb;

endmodule
